// ==== program.hex ====
// One 32-bit instruction per line, word 0 at PC 0; r1 is cleared first and used as zero
28420000 // andi r1, r1, 0
08440064 // addi r2, r1, 100
08460025 // addi r3, r1, 37
084E0002 // addi r7, r1, 2
0853FFC0 // addi r9, r1, -64
00864001 // add  r4, r2, r3
98490020 // sw   r4 -> LEDR
00865000 // sub  r5, r2, r3
984B0020 // sw   r5 -> LEDR
00866007 // xor  r6, r2, r3
984D0020 // sw   r6 -> LEDR
008E800A // sur  r8, r2, r7
98510020 // sw   r8 -> LEDR
024EA00B // ssr  r10, r9, r7
98550020 // sw   r10 -> LEDR
0897FFFD // addi r11, r2, -3
98570020 // sw   r11 -> LEDR
2898003C // andi r12, r2, 0x3C
98590020 // sw   r12 -> LEDR
30DA0140 // ori  r13, r3, 0x140
985B0020 // sw   r13 -> LEDR
40DC0004 // suli r14, r3, 4
985D0020 // sw   r14 -> LEDR
085E02AB // addi r15, r1, 0x2AB
985E0100 // sw   r15 -> [0x100]
80600100 // lw   r16 <- [0x100]
98610020 // sw   r16 -> LEDR
80630120 // lw   r17 <- SWITCH
2C6400FF // andi r18, r17, 0xFF
98650040 // sw   r18 -> LEDG
086603FF // addi r19, r1, 0x3FF  wrong-path marker
08680200 // addi r20, r1, 0x200  marker counter
C0860001 // beq  r2, r3, +1  not taken
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
C0840001 // beq  r2, r2, +1  taken
98670020 // sw   r19 -> LEDR  skipped
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
C8C60001 // bne  r3, r3, +1  not taken
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
C8860001 // bne  r2, r3, +1  taken
98670020 // sw   r19 -> LEDR  skipped
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
D0860001 // blt  r2, r3, +1  not taken
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
D2460001 // blt  r9, r3, +1  taken, signed
98670020 // sw   r19 -> LEDR  skipped
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
D8D20001 // ble  r3, r9, +1  not taken, signed
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
D8C60001 // ble  r3, r3, +1  taken
98670020 // sw   r19 -> LEDR  skipped
0D280001 // addi r20, r20, 1
98690020 // sw   r20 -> LEDR
C043FFFF // beq  r1, r1, -1  spin here

// ==== all.f ====
niuPkg.sv
niuControl.sv
niuFetch.sv
niuRegFile.sv
niuAlu.sv
niuDataMem.sv
niuTop.sv
niuTop_checker.sv
tb_niuTop.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_niuTop -f all.f
./obj_dir/Vtb_niuTop +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

// ==== tb_niuTop.sv ====
`timescale 1ns/1ps

module tb_niuTop;

    localparam int RESET_CYCLES  = 8;
    localparam int PROGRAM_WORDS = 61;
    localparam int LEDR_COUNT    = 18;
    localparam int IDLE_CYCLES   = 20;
    // Slowest instruction is a taken branch at 8 cycles
    localparam int CYCLE_LIMIT   = RESET_CYCLES + PROGRAM_WORDS * 8 + 40;

    logic       clk = 1'b0;
    logic       reset;
    logic [9:0] switches;
    logic [9:0] ledr;
    logic [7:0] ledg;

    // ledr values in program order, worked out by hand
    logic [9:0] ledrExpect [LEDR_COUNT] = '{
        10'h089, 10'h03F, 10'h041, 10'h019, 10'h3F0,  // 100+37, 100-37, 100^37, 100>>2, -64>>>2
        10'h061, 10'h024, 10'h165, 10'h250,           // 100-3, 100&3C, 37|140, 37<<4
        10'h2AB,                                      // Stored word read back
        10'h201, 10'h202, 10'h203, 10'h204,           // Branch markers
        10'h205, 10'h206, 10'h207, 10'h208
    };
    string ledrTest [LEDR_COUNT] = '{
        "ADD", "SUB", "XOR", "SUR", "SSR", "ADDI", "ANDI", "ORI", "SULI", "SW LW echo",
        "BEQ not taken", "BEQ taken", "BNE not taken", "BNE taken",
        "BLT not taken", "BLT taken", "BLE not taken", "BLE taken"
    };

    logic [9:0] ledrPrev = '0;
    logic [7:0] ledgPrev = '0;
    logic [9:0] swValue  = '0;
    logic       timedOut = 1'b0;
    int ledrSeen = 0;
    int ledgSeen = 0;
    int errors   = 0;
    int cycles   = 0;

    niuTop u_niuTop (
        .clk(clk), .reset(reset), .switches(switches), .ledr(ledr), .ledg(ledg)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // LED outputs are registered, so look at them mid-cycle
    always @(negedge clk) begin
        if (!reset && ledr != ledrPrev) begin
            if (ledrSeen < LEDR_COUNT) begin
                assert (ledr == ledrExpect[ledrSeen]) else begin
                    $display("FAILED %s: expected %h, actual %h",
                             ledrTest[ledrSeen], ledrExpect[ledrSeen], ledr);
                    errors++;
                end
            end else begin
                $display("ledr changed to %h after the last expected value", ledr);
                errors++;
            end
            ledrSeen++;
            ledrPrev = ledr;
        end
        if (!reset && ledg != ledgPrev) begin
            assert (ledgSeen == 0) else begin
                $display("ledg changed a second time, to %h", ledg);
                errors++;
            end
            assert (ledg == swValue[7:0]) else begin
                $display("FAILED switch echo: expected %h, actual %h", swValue[7:0], ledg);
                errors++;
            end
            ledgSeen++;
            ledgPrev = ledg;
        end
    end

    initial begin
        logic [31:0] rnd;
        rnd      = lcgNext(32'h736cec92);
        reset    = 1'b1;
        switches = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        swValue  = rnd[25:16] | 10'h001;  // Low byte never zero so the LEDG store is seen
        switches <= swValue;

        while (!(ledrSeen == LEDR_COUNT && ledgSeen == 1) && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        if (cycles >= CYCLE_LIMIT) begin
            timedOut = 1'b1;
            $display("Timeout after %0d cycles with %0d of %0d ledr values and %0d ledg value",
                     cycles, ledrSeen, LEDR_COUNT, ledgSeen);
        end else begin
            repeat (IDLE_CYCLES) @(posedge clk);  // Program now spins, no more LED stores
        end

        $display("Errors: %0d LED checks, %0d assertions, %0d timeouts",
                 errors, u_niuTop.u_niuTopChecker.failCount, timedOut);
        if (errors == 0 && u_niuTop.u_niuTopChecker.failCount == 0 && !timedOut) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== niuTop_checker.sv ====
`timescale 1ns/1ps

module niuTop_checker (
    input logic              clk,
    input logic              reset,
    input niuPkg::ctrlT      ctrl,
    input niuPkg::wordT      mar,
    input niuPkg::ctrlStateT state,
    input logic [9:0]        ledr,
    input logic [7:0]        ledg
);
    import niuPkg::*;

    int   failCount = 0;
    logic ledStored;  // Some LED store has happened
    logic ledrWrite, ledgWrite;

    assign ledrWrite = ctrl.writeMem && (mar == ADDR_LEDR);
    assign ledgWrite = ctrl.writeMem && (mar == ADDR_LEDG);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ledStored <= 1'b0;
        end else if (ledrWrite || ledgWrite) begin
            ledStored <= 1'b1;
        end
    end

    noErrorState: assert property (@(posedge clk) disable iff (reset) state != ERROR)
        else begin
            failCount++;
            $error("Controller entered the ERROR state");
        end

    // LEDs hold their reset value until the program writes one
    ledsQuietAtStart: assert property (@(posedge clk) disable iff (reset)
        !ledStored |-> (ledr == '0 && ledg == '0))
        else begin
            failCount++;
            $error("LED output is not zero before any LED store");
        end

    ledrOnlyOnWrite: assert property (@(posedge clk) disable iff (reset)
        $changed(ledr) |-> $past(ledrWrite))
        else begin
            failCount++;
            $error("ledr changed without a store to the red LED address");
        end

    ledgOnlyOnWrite: assert property (@(posedge clk) disable iff (reset)
        $changed(ledg) |-> $past(ledgWrite))
        else begin
            failCount++;
            $error("ledg changed without a store to the green LED address");
        end

endmodule

bind niuTop niuTop_checker u_niuTopChecker (
    .clk(clk), .reset(reset), .ctrl(ctrl), .mar(u_niuDataMem.mar),
    .state(u_niuControl.state), .ledr(ledr), .ledg(ledg)
);

// ==== niuTop.sv ====
`timescale 1ns/1ps

module niuTop (
    input  logic       clk,
    input  logic       reset,
    input  logic [9:0] switches,
    output logic [9:0] ledr,
    output logic [7:0] ledg
);
    import niuPkg::*;

    ctrlT   ctrl;
    wordT   bus;
    wordT   pc, imm, readData, aluResult, mdr;
    opT     op1, op2;
    regIdxT rx, ry, rz;
    logic   cmpTrue;

    niuControl u_niuControl (
        .clk(clk), .reset(reset), .op1(op1), .op2(op2),
        .rx(rx), .ry(ry), .rz(rz), .cmpTrue(cmpTrue), .ctrl(ctrl)
    );

    niuFetch u_niuFetch (
        .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus), .pc(pc),
        .op1(op1), .op2(op2), .rx(rx), .ry(ry), .rz(rz), .imm(imm)
    );

    niuRegFile u_niuRegFile (.clk(clk), .ctrl(ctrl), .bus(bus), .readData(readData));

    niuAlu u_niuAlu (
        .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus),
        .result(aluResult), .cmpTrue(cmpTrue)
    );

    niuDataMem u_niuDataMem (
        .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus),
        .switches(switches), .mdr(mdr), .ledr(ledr), .ledg(ledg)
    );

    // Shared result bus
    always_comb begin
        case (ctrl.busSrc)
            PC:      bus = pc;
            REG:     bus = readData;
            MEM:     bus = mdr;
            ALU:     bus = aluResult;
            IMM:     bus = imm;
            IMMWORD: bus = imm << MEM_WORD_OFFSET;  // Branch offset in words
            default: bus = '0;
        endcase
    end

endmodule

// ==== niuDataMem.sv ====
`timescale 1ns/1ps

module niuDataMem (
    input  logic         clk,
    input  logic         reset,
    input  niuPkg::ctrlT ctrl,
    input  niuPkg::wordT bus,
    input  logic [9:0]   switches,
    output niuPkg::wordT mdr,
    output logic [9:0]   ledr,
    output logic [7:0]   ledg
);
    import niuPkg::*;

    wordT dmem [DMEM_WORDS];
    wordT mar;
    logic [$clog2(DMEM_WORDS)-1:0] memIdx;
    logic isIo;

    assign memIdx = mar[MEM_WORD_OFFSET +: $clog2(DMEM_WORDS)];
    assign isIo   = (mar == ADDR_LEDR) || (mar == ADDR_LEDG);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mar  <= '0;
            ledr <= '0;
            ledg <= '0;
        end else begin
            if (ctrl.loadMar) mar <= bus;
            if (ctrl.writeMem && mar == ADDR_LEDR) ledr <= bus[9:0];
            if (ctrl.writeMem && mar == ADDR_LEDG) ledg <= bus[7:0];
        end
    end

    // Word memory and MDR, one cycle behind the MAR
    always_ff @(posedge clk) begin
        if (ctrl.writeMem && !isIo) begin
            dmem[memIdx] <= bus;
        end
        if (mar == ADDR_SWITCH) begin
            mdr <= {22'b0, switches};
        end else begin
            mdr <= dmem[memIdx];
        end
    end

endmodule

// ==== niuAlu.sv ====
`timescale 1ns/1ps

module niuAlu (
    input  logic         clk,
    input  logic         reset,
    input  niuPkg::ctrlT ctrl,
    input  niuPkg::wordT bus,
    output niuPkg::wordT result,
    output logic         cmpTrue
);
    import niuPkg::*;

    wordT opA, opB;
    logic [4:0] shamt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opA <= '0;
            opB <= '0;
        end else begin
            if (ctrl.loadA) opA <= bus;
            if (ctrl.loadB) opB <= bus;
        end
    end

    assign shamt = opB[4:0];

    always_comb begin
        case (ctrl.aluFunc)
            OP2_SUB: result = opA - opB;
            OP2_ADD: result = opA + opB;
            OP2_NOT: result = ~opA;
            OP2_AND: result = opA & opB;
            OP2_OR:  result = opA | opB;
            OP2_XOR: result = opA ^ opB;
            OP2_SUL: result = opA << shamt;
            OP2_SUR: result = opA >> shamt;
            OP2_SSR: result = wordT'($signed(opA) >>> shamt);  // Keeps the sign
            OP2_EQ:  result = wordT'(opA == opB);
            OP2_NEQ: result = wordT'(opA != opB);
            OP2_LT:  result = wordT'($signed(opA) < $signed(opB));
            OP2_LEQ: result = wordT'($signed(opA) <= $signed(opB));
            default: result = '0;
        endcase
    end

    assign cmpTrue = result[0];  // Branch test in BR2

endmodule

// ==== niuRegFile.sv ====
`timescale 1ns/1ps

module niuRegFile (
    input  logic         clk,
    input  niuPkg::ctrlT ctrl,
    input  niuPkg::wordT bus,
    output niuPkg::wordT readData
);
    import niuPkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (ctrl.writeReg) begin
            regs[ctrl.regSel] <= bus;
        end
    end

    // Same select serves read and write
    assign readData = regs[ctrl.regSel];

endmodule

// ==== niuFetch.sv ====
`timescale 1ns/1ps

module niuFetch (
    input  logic           clk,
    input  logic           reset,
    input  niuPkg::ctrlT   ctrl,
    input  niuPkg::wordT   bus,
    output niuPkg::wordT   pc,
    output niuPkg::opT     op1,
    output niuPkg::opT     op2,
    output niuPkg::regIdxT rx,
    output niuPkg::regIdxT ry,
    output niuPkg::regIdxT rz,
    output niuPkg::wordT   imm
);
    import niuPkg::*;

    wordT imem [IMEM_WORDS];
    wordT ir;
    immT  immField;

    initial begin
        $readmemh("program.hex", imem);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= PC_START;
            ir <= '0;
        end else begin
            if (ctrl.loadPc) begin
                pc <= bus;
            end else if (ctrl.incPc) begin
                pc <= pc + INSTR_BYTES;
            end
            if (ctrl.loadIr) begin
                ir <= imem[pc[MEM_WORD_OFFSET +: $clog2(IMEM_WORDS)]];
            end
        end
    end

    // Instruction fields
    assign op1      = ir[31:27];
    assign rx       = ir[26:22];
    assign ry       = ir[21:17];
    assign rz       = ir[16:12];
    assign op2      = ir[4:0];
    assign immField = ir[16:0];
    assign imm      = {{($bits(wordT) - $bits(immT)){immField[16]}}, immField};

endmodule

// ==== niuControl.sv ====
`timescale 1ns/1ps

module niuControl (
    input  logic           clk,
    input  logic           reset,
    input  niuPkg::opT     op1,
    input  niuPkg::opT     op2,
    input  niuPkg::regIdxT rx,
    input  niuPkg::regIdxT ry,
    input  niuPkg::regIdxT rz,
    input  logic           cmpTrue,
    output niuPkg::ctrlT   ctrl
);
    import niuPkg::*;

    ctrlStateT state, nextState;
    logic isRegOp;

    // Immediate opcode to ALU function
    function automatic opT immFunc(input opT op);
        case (op)
            OP1_ANDI: return OP2_AND;
            OP1_ORI:  return OP2_OR;
            OP1_XORI: return OP2_XOR;
            OP1_SULI: return OP2_SUL;
            OP1_SURI: return OP2_SUR;
            OP1_SSRI: return OP2_SSR;
            default:  return OP2_ADD;
        endcase
    endfunction

    function automatic opT branchFunc(input opT op);
        case (op)
            OP1_BNE: return OP2_NEQ;
            OP1_BLT: return OP2_LT;
            OP1_BLE: return OP2_LEQ;
            default: return OP2_EQ;
        endcase
    endfunction

    function automatic logic validFunc(input opT func);
        case (func)
            OP2_SUB, OP2_ADD, OP2_NOT, OP2_AND, OP2_OR, OP2_XOR,
            OP2_SUL, OP2_SUR, OP2_SSR,
            OP2_EQ, OP2_NEQ, OP2_LT, OP2_LEQ: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign isRegOp = (op1 == OP1_ALUR);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            FETCH:  nextState = DECODE;
            DECODE: begin
                case (op1)
                    OP1_ALUR: nextState = validFunc(op2) ? ALU0 : ERROR;
                    OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI,
                    OP1_SULI, OP1_SURI, OP1_SSRI: nextState = ALU0;
                    OP1_LW, OP1_SW: nextState = MEM0;
                    OP1_BEQ, OP1_BNE, OP1_BLT, OP1_BLE: nextState = BR0;
                    default: nextState = ERROR;
                endcase
            end
            ALU0:   nextState = ALU1;
            ALU1:   nextState = ALU2;
            ALU2:   nextState = FETCH;
            MEM0:   nextState = MEM1;
            MEM1:   nextState = MEM2;
            MEM2:   nextState = MEM3;
            MEM3:   nextState = MEM4;
            MEM4:   nextState = FETCH;
            BR0:    nextState = BR1;
            BR1:    nextState = BR2;
            BR2:    nextState = cmpTrue ? BR3 : FETCH;  // Taken branch goes on
            BR3:    nextState = BR4;
            BR4:    nextState = BR5;
            BR5:    nextState = FETCH;
            ERROR:  nextState = ERROR;  // Held until reset
            default: nextState = ERROR;
        endcase
    end

    // Control word per state
    always_comb begin
        ctrl = '0;
        ctrl.busSrc = NONE;
        case (state)
            FETCH: begin
                ctrl.loadIr = 1'b1;
                ctrl.incPc  = 1'b1;
            end
            ALU0: begin
                ctrl.busSrc = isRegOp ? REG : IMM;
                ctrl.regSel = ry;
                ctrl.loadB  = 1'b1;
            end
            ALU1, MEM0, BR0: begin
                ctrl.busSrc = REG;
                ctrl.regSel = rx;
                ctrl.loadA  = 1'b1;
            end
            ALU2: begin
                ctrl.busSrc   = ALU;
                ctrl.aluFunc  = isRegOp ? op2 : immFunc(op1);
                ctrl.regSel   = isRegOp ? rz : ry;  // Immediate form writes ry
                ctrl.writeReg = 1'b1;
            end
            MEM1: begin
                ctrl.busSrc = IMM;
                ctrl.loadB  = 1'b1;
            end
            MEM2: begin
                ctrl.busSrc  = ALU;
                ctrl.aluFunc = OP2_ADD;
                ctrl.loadMar = 1'b1;
            end
            MEM3: ;  // MDR picks up the word
            MEM4: begin
                ctrl.regSel = ry;
                if (op1 == OP1_LW) begin
                    ctrl.busSrc   = MEM;
                    ctrl.writeReg = 1'b1;
                end else begin
                    ctrl.busSrc   = REG;
                    ctrl.writeMem = 1'b1;
                end
            end
            BR1: begin
                ctrl.busSrc = REG;
                ctrl.regSel = ry;
                ctrl.loadB  = 1'b1;
            end
            BR2: ctrl.aluFunc = branchFunc(op1);
            BR3: begin
                ctrl.busSrc = PC;  // Already old PC plus 4
                ctrl.loadA  = 1'b1;
            end
            BR4: begin
                ctrl.busSrc = IMMWORD;
                ctrl.loadB  = 1'b1;
            end
            BR5: begin
                ctrl.busSrc  = ALU;
                ctrl.aluFunc = OP2_ADD;
                ctrl.loadPc  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== niuPkg.sv ====
package niuPkg;

    // Vector types with a meaning
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [4:0]  opT;     // Opcode or ALU function
    typedef logic [16:0] immT;

    localparam int   INSTR_BYTES     = 4;
    localparam int   IMEM_WORDS      = 2048;
    localparam int   DMEM_WORDS      = 2048;
    localparam int   MEM_WORD_OFFSET = 2;  // Byte address to word index
    localparam wordT PC_START        = 32'h0000_0000;

    // Memory-mapped I/O
    localparam wordT ADDR_LEDR   = 32'hFFFF_0020;
    localparam wordT ADDR_LEDG   = 32'hFFFF_0040;
    localparam wordT ADDR_SWITCH = 32'hFFFF_0120;

    // Primary opcodes
    localparam opT OP1_ALUR = 5'b00000;
    localparam opT OP1_ADDI = 5'b00001;
    localparam opT OP1_ANDI = 5'b00101;
    localparam opT OP1_ORI  = 5'b00110;
    localparam opT OP1_XORI = 5'b00111;
    localparam opT OP1_SULI = 5'b01000;
    localparam opT OP1_SURI = 5'b01010;
    localparam opT OP1_SSRI = 5'b01011;
    localparam opT OP1_LW   = 5'b10000;
    localparam opT OP1_SW   = 5'b10011;
    localparam opT OP1_BEQ  = 5'b11000;
    localparam opT OP1_BNE  = 5'b11001;
    localparam opT OP1_BLT  = 5'b11010;
    localparam opT OP1_BLE  = 5'b11011;

    // Secondary functions, also the ALU function codes
    localparam opT OP2_SUB = 5'b00000;
    localparam opT OP2_ADD = 5'b00001;
    localparam opT OP2_NOT = 5'b00100;
    localparam opT OP2_AND = 5'b00101;
    localparam opT OP2_OR  = 5'b00110;
    localparam opT OP2_XOR = 5'b00111;
    localparam opT OP2_SUL = 5'b01000;
    localparam opT OP2_SUR = 5'b01010;
    localparam opT OP2_SSR = 5'b01011;
    localparam opT OP2_EQ  = 5'b10000;
    localparam opT OP2_NEQ = 5'b10001;
    localparam opT OP2_LT  = 5'b10010;
    localparam opT OP2_LEQ = 5'b10011;

    typedef enum logic [4:0] {
        FETCH, DECODE,
        ALU0, ALU1, ALU2,
        MEM0, MEM1, MEM2, MEM3, MEM4,
        BR0, BR1, BR2, BR3, BR4, BR5,
        ERROR
    } ctrlStateT;

    typedef enum logic [2:0] {
        NONE, PC, REG, MEM, ALU, IMM, IMMWORD
    } busSrcT;

    typedef struct packed {
        busSrcT busSrc;
        logic   loadPc;
        logic   incPc;
        logic   loadIr;
        logic   loadA;
        logic   loadB;
        logic   loadMar;
        logic   writeReg;
        logic   writeMem;
        regIdxT regSel;
        opT     aluFunc;
    } ctrlT;

endpackage
